/* Bender.yml */
package:
  name: icache_ctrl

sources:
  - icache_ctrl_pkg.sv
  - icache_ack_tracker.sv
  - icache_ctrl_regs.sv
  - icache_ctrl_fsm.sv
  - icache_ctrl_top.sv
  - target: test
    files:
      - icache_ctrl_properties.sv
      - tb_icache_ctrl.sv

/* files.f */
icache_ctrl_pkg.sv
icache_ack_tracker.sv
icache_ctrl_regs.sv
icache_ctrl_fsm.sv
icache_ctrl_top.sv
icache_ctrl_properties.sv
tb_icache_ctrl.sv

/* icache_ack_tracker.sv */
//**************************************************************************
// Tracks the pending acknowledgements of one cache level during a command.
// Loaded with a participation mask on start, it drives the flush requests
// of the pending units and reports done once every unit has answered.
// Instantiated once for the L1 ports and once for the L2 banks.
//**************************************************************************

`default_nettype none
`timescale 1ns/10ps

module icache_ack_tracker #(
   parameter int unsigned N = 1
) (
   input  logic                        clk_i,
   input  logic                        rst_ni,

   input  logic                        start_i,
   input  icache_ctrl_pkg::cache_cmd_e cmd_i,
   input  logic [N-1:0]                part_i,

   input  logic [N-1:0]                enable_ack_i,
   input  logic [N-1:0]                disable_ack_i,
   input  logic [N-1:0]                flush_ack_i,
   input  logic [N-1:0]                sel_flush_ack_i,

   output logic [N-1:0]                flush_req_o,
   output logic [N-1:0]                sel_flush_req_o,
   output logic                        done_o
);

   logic [N-1:0]                pending_q;
   logic [N-1:0]                ack_match;
   icache_ctrl_pkg::cache_cmd_e cmd_q;

   // Pick the ack that completes the command in flight
   always_comb begin
      case (cmd_q)
         icache_ctrl_pkg::CMD_ENABLE:    ack_match = enable_ack_i;
         icache_ctrl_pkg::CMD_DISABLE:   ack_match = disable_ack_i;
         icache_ctrl_pkg::CMD_FLUSH:     ack_match = flush_ack_i;
         icache_ctrl_pkg::CMD_SEL_FLUSH: ack_match = sel_flush_ack_i;
         default:                        ack_match = '0;
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         pending_q <= '0;
         cmd_q     <= icache_ctrl_pkg::CMD_DISABLE;
      end else if (start_i) begin
         pending_q <= part_i;
         cmd_q     <= cmd_i;
      end else begin
         pending_q <= pending_q & ~ack_match;  // Drop units that answered
      end
   end

   // Requests are levels, held while the unit is still pending
   assign flush_req_o     = (cmd_q == icache_ctrl_pkg::CMD_FLUSH) ? pending_q : '0;
   assign sel_flush_req_o = (cmd_q == icache_ctrl_pkg::CMD_SEL_FLUSH) ? pending_q : '0;

   assign done_o = ~|pending_q;

endmodule

`default_nettype wire

/* icache_ctrl_fsm.sv */
//**************************************************************************
// Bus sequencer of the instruction cache control unit.
// Grants in IDLE and answers plain accesses on the next cycle. A command
// write moves it to BUSY until both cache levels report done, then it
// answers the bus and clears the flush register.
//**************************************************************************

`default_nettype none
`timescale 1ns/10ps

module icache_ctrl_fsm #(
   parameter int unsigned IdWidth = 5
) (
   input  logic               clk_i,
   input  logic               rst_ni,

   input  logic               req_i,
   input  logic               wen_i,      // 1 is a read
   input  logic [IdWidth-1:0] id_i,
   output logic               gnt_o,

   input  logic               cmd_valid_i,
   input  logic               l1_done_i,
   input  logic               l2_done_i,

   output logic               wr_en_o,
   output logic               rd_en_o,
   output logic               clear_flush_o,

   output logic               r_valid_o,
   output logic               r_opc_o,
   output logic [IdWidth-1:0] r_id_o
);

   icache_ctrl_pkg::seq_state_e state_q;
   icache_ctrl_pkg::seq_state_e state_d;

   logic               accept;
   logic               finish;
   logic               resp_d;
   logic               r_valid_q;
   logic [IdWidth-1:0] r_id_q;

   assign gnt_o  = (state_q == icache_ctrl_pkg::IDLE);
   assign accept = req_i & gnt_o;

   assign wr_en_o = accept & ~wen_i;
   assign rd_en_o = accept & wen_i;

   // Command done on both levels
   assign finish        = (state_q == icache_ctrl_pkg::BUSY) & l1_done_i & l2_done_i;
   assign clear_flush_o = finish;

   always_comb begin
      state_d = state_q;
      case (state_q)
         icache_ctrl_pkg::IDLE: begin
            if (cmd_valid_i) begin
               state_d = icache_ctrl_pkg::BUSY;
            end
         end
         icache_ctrl_pkg::BUSY: begin
            if (finish) begin
               state_d = icache_ctrl_pkg::IDLE;
            end
         end
         default: state_d = icache_ctrl_pkg::IDLE;
      endcase
   end

   // Plain accesses answer at once, commands when the caches are done
   assign resp_d = (accept & ~cmd_valid_i) | finish;

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         state_q   <= icache_ctrl_pkg::IDLE;
         r_valid_q <= 1'b0;
      end else begin
         state_q   <= state_d;
         r_valid_q <= resp_d;
      end
   end

   // Id of the access in flight
   always_ff @(posedge clk_i) begin
      if (accept) begin
         r_id_q <= id_i;
      end
   end

   assign r_valid_o = r_valid_q;
   assign r_id_o    = r_id_q;
   assign r_opc_o   = 1'b0;     // No error responses

endmodule

`default_nettype wire

/* icache_ctrl_pkg.sv */
//**************************************************************************
// Shared constants and types of the instruction cache control unit.
// Register word offsets are decoded from address bits 7 to 2 of the
// peripheral port. Other files refer to these by scoped names.
//**************************************************************************

`default_nettype none

package icache_ctrl_pkg;

   // Width of bus data, address and selective-flush address
   localparam int unsigned DataWidth = 32;

   // Word offset field taken from the bus address
   localparam int unsigned RegOffsetWidth = 6;

   localparam logic [RegOffsetWidth-1:0] RegEnable   = 6'd0;  // Enable or disable all caches
   localparam logic [RegOffsetWidth-1:0] RegFlush    = 6'd1;  // Flush L1 and L2
   localparam logic [RegOffsetWidth-1:0] RegFlushL1  = 6'd2;  // Flush L1 ports only
   localparam logic [RegOffsetWidth-1:0] RegSelFlush = 6'd3;  // Flush one address everywhere
   localparam logic [RegOffsetWidth-1:0] RegPrefetch = 6'd7;  // Per-core prefetch enable

   // Read data for any offset that is not mapped
   localparam logic [DataWidth-1:0] UnmappedValue = 32'hDEAD_CA5E;

   // Command handed to the ack trackers, selects which ack clears a unit
   typedef enum logic [1:0] {
      CMD_ENABLE    = 2'b00,
      CMD_DISABLE   = 2'b01,
      CMD_FLUSH     = 2'b10,
      CMD_SEL_FLUSH = 2'b11
   } cache_cmd_e;

   // Bus sequencer state
   typedef enum logic {
      IDLE = 1'b0,  // Granting, single-cycle answers
      BUSY = 1'b1   // Waiting for cache acks
   } seq_state_e;

endpackage

`default_nettype wire

/* icache_ctrl_properties.sv */
//**************************************************************************
// Bus protocol assertions of the cache control sequencer.
// Bound into every icache_ctrl_fsm instance.
// The testbench adds fail_cnt to its own error count.
//**************************************************************************

`default_nettype none
`timescale 1ns/10ps

module icache_ctrl_properties (
   input logic                        clk_i,
   input logic                        rst_ni,
   input icache_ctrl_pkg::seq_state_e state_i,
   input logic                        gnt_i,
   input logic                        r_valid_i
);

   int fail_cnt = 0;

   // One response per access, never back to back
   single_response: assert property (@(posedge clk_i) disable iff (!rst_ni)
      r_valid_i |=> !r_valid_i)
      else begin
         $error("r_valid_o high two cycles in a row");
         fail_cnt++;
      end

   // No answer while the caches are still working
   quiet_while_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (state_i == icache_ctrl_pkg::BUSY) |-> !r_valid_i)
      else begin
         $error("r_valid_o high in BUSY");
         fail_cnt++;
      end

   // Grant comes back only together with the command response
   grant_with_response: assert property (@(posedge clk_i) disable iff (!rst_ni)
      $rose(gnt_i) |-> r_valid_i)
      else begin
         $error("gnt_o returned without a response");
         fail_cnt++;
      end

endmodule

bind icache_ctrl_fsm icache_ctrl_properties i_props (
   .clk_i     (clk_i),
   .rst_ni    (rst_ni),
   .state_i   (state_q),
   .gnt_i     (gnt_o),
   .r_valid_i (r_valid_o)
);

`default_nettype wire

/* icache_ctrl_regs.sv */
//**************************************************************************
// Control registers of the instruction cache control unit.
// Decodes bus writes, launches commands towards the ack trackers and
// registers the read data one cycle after an accepted access.
// Write and read strobes come from the bus sequencer.
//**************************************************************************

`default_nettype none
`timescale 1ns/10ps

module icache_ctrl_regs #(
   parameter int unsigned NbCores = 8,
   parameter int unsigned NbBanks = 4
) (
   input  logic                                     clk_i,
   input  logic                                     rst_ni,

   input  logic                                     wr_en_i,
   input  logic                                     rd_en_i,
   input  logic                                     clear_flush_i,
   input  logic [icache_ctrl_pkg::DataWidth-1:0]    addr_i,
   input  logic [icache_ctrl_pkg::DataWidth-1:0]    wdata_i,
   output logic [icache_ctrl_pkg::DataWidth-1:0]    rdata_o,

   output logic [NbCores+NbBanks-1:0]               enable_o,
   output logic [icache_ctrl_pkg::DataWidth-1:0]    sel_flush_addr_o,
   output logic [NbCores-1:0]                       prefetch_o,

   output logic                                     cmd_valid_o,
   output icache_ctrl_pkg::cache_cmd_e              cmd_o,
   output logic [NbCores-1:0]                       l1_part_o,
   output logic [NbBanks-1:0]                       l2_part_o
);

   localparam int unsigned NbUnits = NbCores + NbBanks;

   logic [icache_ctrl_pkg::RegOffsetWidth-1:0] offset;
   logic [NbUnits-1:0]                         enable_q;
   logic [NbUnits-1:0]                         flush_q;
   logic [icache_ctrl_pkg::DataWidth-1:0]      sel_flush_q;
   logic [NbCores-1:0]                         prefetch_q;
   logic [icache_ctrl_pkg::DataWidth-1:0]      enable_word;
   logic [icache_ctrl_pkg::DataWidth-1:0]      flush_word;
   logic [icache_ctrl_pkg::DataWidth-1:0]      prefetch_word;
   logic [icache_ctrl_pkg::DataWidth-1:0]      rdata_q;

   assign offset = addr_i[icache_ctrl_pkg::RegOffsetWidth+1:2];

   // Command launch, same cycle as the accepted write
   always_comb begin
      cmd_valid_o = 1'b0;
      cmd_o       = icache_ctrl_pkg::CMD_ENABLE;
      l1_part_o   = '0;
      l2_part_o   = '0;
      if (wr_en_i) begin
         case (offset)
            icache_ctrl_pkg::RegEnable: begin
               cmd_valid_o = 1'b1;
               cmd_o       = wdata_i[0] ? icache_ctrl_pkg::CMD_ENABLE
                                        : icache_ctrl_pkg::CMD_DISABLE;
               l1_part_o   = '1;
               l2_part_o   = '1;
            end
            icache_ctrl_pkg::RegFlush: begin
               cmd_valid_o = 1'b1;
               cmd_o       = icache_ctrl_pkg::CMD_FLUSH;
               l1_part_o   = {NbCores{wdata_i[0]}};
               l2_part_o   = {NbBanks{wdata_i[0]}};
            end
            icache_ctrl_pkg::RegFlushL1: begin
               cmd_valid_o = 1'b1;
               cmd_o       = icache_ctrl_pkg::CMD_FLUSH;
               l1_part_o   = {NbCores{wdata_i[0]}};  // Banks stay out
            end
            icache_ctrl_pkg::RegSelFlush: begin
               cmd_valid_o = 1'b1;
               cmd_o       = icache_ctrl_pkg::CMD_SEL_FLUSH;
               l1_part_o   = '1;
               l2_part_o   = '1;
            end
            default: ;  // Prefetch and unmapped writes launch nothing
         endcase
      end
   end

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         enable_q    <= '0;
         flush_q     <= '0;
         sel_flush_q <= '0;
         prefetch_q  <= '0;
      end else if (wr_en_i) begin
         case (offset)
            icache_ctrl_pkg::RegEnable:   enable_q    <= {NbUnits{wdata_i[0]}};
            icache_ctrl_pkg::RegFlush:    flush_q     <= {NbUnits{wdata_i[0]}};
            icache_ctrl_pkg::RegFlushL1:  flush_q     <= {{NbBanks{1'b0}}, {NbCores{wdata_i[0]}}};
            icache_ctrl_pkg::RegSelFlush: sel_flush_q <= wdata_i;
            icache_ctrl_pkg::RegPrefetch: prefetch_q  <= wdata_i[NbCores-1:0];
            default: ;
         endcase
      end else if (clear_flush_i) begin
         flush_q <= '0;  // Flush finished on every unit
      end
   end

   // Zero-extended views for read-back
   always_comb begin
      enable_word                  = '0;
      enable_word[NbUnits-1:0]     = enable_q;
      flush_word                   = '0;
      flush_word[NbUnits-1:0]      = flush_q;
      prefetch_word                = '0;
      prefetch_word[NbCores-1:0]   = prefetch_q;
   end

   always_ff @(posedge clk_i) begin
      if (rd_en_i) begin
         case (offset)
            icache_ctrl_pkg::RegEnable:   rdata_q <= enable_word;
            icache_ctrl_pkg::RegFlush:    rdata_q <= flush_word;
            icache_ctrl_pkg::RegSelFlush: rdata_q <= sel_flush_q;
            icache_ctrl_pkg::RegPrefetch: rdata_q <= prefetch_word;
            default:                      rdata_q <= icache_ctrl_pkg::UnmappedValue;
         endcase
      end else if (wr_en_i) begin
         rdata_q <= '0;  // Writes answer with zero
      end
   end

   assign rdata_o          = rdata_q;
   assign enable_o         = enable_q;
   assign sel_flush_addr_o = sel_flush_q;
   assign prefetch_o       = prefetch_q;

endmodule

`default_nettype wire

/* icache_ctrl_top.sv */
//**************************************************************************
// Top level of the two-level instruction cache control unit.
// Connects the peripheral port to the registers and the bus sequencer,
// and drives the L1 ports and L2 banks through one ack tracker each.
//**************************************************************************

`default_nettype none
`timescale 1ns/10ps

module icache_ctrl_top #(
   parameter int unsigned NbCores = 8,
   parameter int unsigned NbBanks = 4,
   parameter int unsigned IdWidth = 5
) (
   input  logic                                  clk_i,
   input  logic                                  rst_ni,

   input  logic                                  req_i,
   input  logic [icache_ctrl_pkg::DataWidth-1:0] addr_i,
   input  logic                                  wen_i,
   input  logic [icache_ctrl_pkg::DataWidth-1:0] wdata_i,
   input  logic [3:0]                            be_i,     // Byte enables not used
   input  logic [IdWidth-1:0]                    id_i,
   output logic                                  gnt_o,
   output logic                                  r_valid_o,
   output logic                                  r_opc_o,
   output logic [IdWidth-1:0]                    r_id_o,
   output logic [icache_ctrl_pkg::DataWidth-1:0] r_rdata_o,

   output logic [NbCores-1:0]                    l1_bypass_req_o,
   input  logic [NbCores-1:0]                    l1_bypass_ack_i,
   output logic [NbCores-1:0]                    l1_flush_req_o,
   input  logic [NbCores-1:0]                    l1_flush_ack_i,
   output logic [NbCores-1:0]                    l1_sel_flush_req_o,
   output logic [icache_ctrl_pkg::DataWidth-1:0] l1_sel_flush_addr_o,
   input  logic [NbCores-1:0]                    l1_sel_flush_ack_i,

   output logic [NbBanks-1:0]                    l2_enable_req_o,
   input  logic [NbBanks-1:0]                    l2_enable_ack_i,
   output logic [NbBanks-1:0]                    l2_disable_req_o,
   input  logic [NbBanks-1:0]                    l2_disable_ack_i,
   output logic [NbBanks-1:0]                    l2_flush_req_o,
   input  logic [NbBanks-1:0]                    l2_flush_ack_i,
   output logic [NbBanks-1:0]                    l2_sel_flush_req_o,
   output logic [icache_ctrl_pkg::DataWidth-1:0] l2_sel_flush_addr_o,
   input  logic [NbBanks-1:0]                    l2_sel_flush_ack_i,

   output logic [NbCores-1:0]                    prefetch_enable_o
);

   logic [NbCores+NbBanks-1:0]                  enable;
   logic [icache_ctrl_pkg::DataWidth-1:0]       sel_flush_addr;
   logic                                        wr_en;
   logic                                        rd_en;
   logic                                        clear_flush;
   logic                                        cmd_valid;
   icache_ctrl_pkg::cache_cmd_e                 cmd;
   logic [NbCores-1:0]                          l1_part;
   logic [NbBanks-1:0]                          l2_part;
   logic                                        l1_done;
   logic                                        l2_done;

   // Enable levels straight from the enable register
   assign l1_bypass_req_o     = ~enable[NbCores-1:0];
   assign l2_enable_req_o     = enable[NbCores+NbBanks-1:NbCores];
   assign l2_disable_req_o    = ~enable[NbCores+NbBanks-1:NbCores];
   assign l1_sel_flush_addr_o = sel_flush_addr;
   assign l2_sel_flush_addr_o = sel_flush_addr;

   icache_ctrl_regs #(
      .NbCores (NbCores),
      .NbBanks (NbBanks)
   ) i_regs (
      .clk_i            (clk_i),
      .rst_ni           (rst_ni),
      .wr_en_i          (wr_en),
      .rd_en_i          (rd_en),
      .clear_flush_i    (clear_flush),
      .addr_i           (addr_i),
      .wdata_i          (wdata_i),
      .rdata_o          (r_rdata_o),
      .enable_o         (enable),
      .sel_flush_addr_o (sel_flush_addr),
      .prefetch_o       (prefetch_enable_o),
      .cmd_valid_o      (cmd_valid),
      .cmd_o            (cmd),
      .l1_part_o        (l1_part),
      .l2_part_o        (l2_part)
   );

   icache_ctrl_fsm #(
      .IdWidth (IdWidth)
   ) i_fsm (
      .clk_i         (clk_i),
      .rst_ni        (rst_ni),
      .req_i         (req_i),
      .wen_i         (wen_i),
      .id_i          (id_i),
      .gnt_o         (gnt_o),
      .cmd_valid_i   (cmd_valid),
      .l1_done_i     (l1_done),
      .l2_done_i     (l2_done),
      .wr_en_o       (wr_en),
      .rd_en_o       (rd_en),
      .clear_flush_o (clear_flush),
      .r_valid_o     (r_valid_o),
      .r_opc_o       (r_opc_o),
      .r_id_o        (r_id_o)
   );

   // L1 answers enable and disable through its bypass ack
   icache_ack_tracker #(
      .N (NbCores)
   ) i_l1_tracker (
      .clk_i           (clk_i),
      .rst_ni          (rst_ni),
      .start_i         (cmd_valid),
      .cmd_i           (cmd),
      .part_i          (l1_part),
      .enable_ack_i    (~l1_bypass_ack_i),
      .disable_ack_i   (l1_bypass_ack_i),
      .flush_ack_i     (l1_flush_ack_i),
      .sel_flush_ack_i (l1_sel_flush_ack_i),
      .flush_req_o     (l1_flush_req_o),
      .sel_flush_req_o (l1_sel_flush_req_o),
      .done_o          (l1_done)
   );

   icache_ack_tracker #(
      .N (NbBanks)
   ) i_l2_tracker (
      .clk_i           (clk_i),
      .rst_ni          (rst_ni),
      .start_i         (cmd_valid),
      .cmd_i           (cmd),
      .part_i          (l2_part),
      .enable_ack_i    (l2_enable_ack_i),
      .disable_ack_i   (l2_disable_ack_i),
      .flush_ack_i     (l2_flush_ack_i),
      .sel_flush_ack_i (l2_sel_flush_ack_i),
      .flush_req_o     (l2_flush_req_o),
      .sel_flush_req_o (l2_sel_flush_req_o),
      .done_o          (l2_done)
   );

endmodule

`default_nettype wire

/* tb_icache_ctrl.sv */
//**************************************************************************
// Directed testbench of the instruction cache control unit.
// Drives the peripheral port on the falling edge, models every L1 port
// and L2 bank with randomly delayed acks, and checks each response.
//**************************************************************************

`default_nettype none
`timescale 1ns/10ps

module tb_icache_ctrl;

   localparam int unsigned NbCores  = 8;
   localparam int unsigned NbBanks  = 4;
   localparam int unsigned IdWidth  = 5;
   localparam int unsigned NU       = NbCores + NbBanks;
   localparam int unsigned NumTests = 5;

   logic                                  clk_i = 1'b0;
   logic                                  rst_ni;
   logic                                  req;
   logic [icache_ctrl_pkg::DataWidth-1:0] addr;
   logic                                  wen;
   logic [icache_ctrl_pkg::DataWidth-1:0] wdata;
   logic [IdWidth-1:0]                    id;
   wire                                   gnt, r_valid, r_opc;
   wire  [IdWidth-1:0]                    r_id;
   wire  [icache_ctrl_pkg::DataWidth-1:0] r_rdata, l1_sel_addr, l2_sel_addr;
   wire  [NbCores-1:0]                    l1_bypass_req, l1_flush_req, l1_sel_req, prefetch;
   wire  [NbBanks-1:0]                    l2_enable_req, l2_disable_req, l2_flush_req, l2_sel_req;

   // Per kind rows: 0 bypass or enable, 1 disable, 2 flush, 3 selective flush
   logic [3:0][NU-1:0] req_vec, ack_vec, tgt;
   int                 cnt [4][NU];
   int                 req_cnt [4][NU];
   int                 ack_cnt [4][NU];
   logic [31:0]        lfsr = 32'h7f366272;
   int                 errors = 0;

   always #4 clk_i = ~clk_i;

   assign req_vec = {{l2_sel_req, l1_sel_req}, {l2_flush_req, l1_flush_req},
                     {l2_disable_req, {NbCores{1'b0}}}, {l2_enable_req, l1_bypass_req}};

   icache_ctrl_top #(.NbCores (NbCores), .NbBanks (NbBanks), .IdWidth (IdWidth)) uut (
      .clk_i (clk_i), .rst_ni (rst_ni), .req_i (req), .addr_i (addr), .wen_i (wen),
      .wdata_i (wdata), .be_i (4'hF), .id_i (id), .gnt_o (gnt), .r_valid_o (r_valid),
      .r_opc_o (r_opc), .r_id_o (r_id), .r_rdata_o (r_rdata),
      .l1_bypass_req_o (l1_bypass_req), .l1_bypass_ack_i (ack_vec[0][NbCores-1:0]),
      .l1_flush_req_o (l1_flush_req), .l1_flush_ack_i (ack_vec[2][NbCores-1:0]),
      .l1_sel_flush_req_o (l1_sel_req), .l1_sel_flush_addr_o (l1_sel_addr),
      .l1_sel_flush_ack_i (ack_vec[3][NbCores-1:0]),
      .l2_enable_req_o (l2_enable_req), .l2_enable_ack_i (ack_vec[0][NU-1:NbCores]),
      .l2_disable_req_o (l2_disable_req), .l2_disable_ack_i (ack_vec[1][NU-1:NbCores]),
      .l2_flush_req_o (l2_flush_req), .l2_flush_ack_i (ack_vec[2][NU-1:NbCores]),
      .l2_sel_flush_req_o (l2_sel_req), .l2_sel_flush_addr_o (l2_sel_addr),
      .l2_sel_flush_ack_i (ack_vec[3][NU-1:NbCores]), .prefetch_enable_o (prefetch)
   );

   // Galois LFSR, one step per bit taken
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
         r    = {r[30:0], lfsr[0]};
      end
      return r;
   endfunction

   // Cache models, ack follows its request after 0 to 7 cycles
   always @(negedge clk_i) begin
      for (int k = 0; k < 4; k++) begin
         for (int u = 0; u < NU; u++) begin
            if (req_vec[k][u] !== tgt[k][u]) begin
               tgt[k][u] = req_vec[k][u];
               cnt[k][u] = take_bits(3);
               if (req_vec[k][u]) req_cnt[k][u]++;
            end else if (cnt[k][u] != 0) begin
               cnt[k][u]--;
            end
            if (cnt[k][u] == 0 && ack_vec[k][u] != tgt[k][u]) begin
               ack_vec[k][u] = tgt[k][u];
               if (tgt[k][u]) ack_cnt[k][u]++;
            end
         end
      end
   end

   task automatic note_error(input string msg);
      $display("ERR %0t: %s", $time, msg);
      errors++;
   endtask

   function automatic logic caches_settled();
      for (int k = 0; k < 4; k++)
         for (int u = 0; u < NU; u++)
            if (cnt[k][u] != 0 || ack_vec[k][u] !== req_vec[k][u]) return 1'b0;
      return 1'b1;
   endfunction

   task automatic clear_counts();
      while (!caches_settled()) @(negedge clk_i);
      for (int k = 0; k < 4; k++)
         for (int u = 0; u < NU; u++) begin
            req_cnt[k][u] = 0;
            ack_cnt[k][u] = 0;
         end
   endtask

   task automatic check_counts(input int k, input int exp_l1, input int exp_l2);
      int exp;
      for (int u = 0; u < NU; u++) begin
         exp = (u < NbCores) ? exp_l1 : exp_l2;
         if (req_cnt[k][u] != exp || ack_cnt[k][u] != exp)
            note_error($sformatf("unit %0d kind %0d saw %0d req %0d ack, expected %0d",
                                 u, k, req_cnt[k][u], ack_cnt[k][u], exp));
      end
   endtask

   // One access, checks grant, latency and response id
   task automatic bus_access(input logic is_read, input logic [5:0] off,
                             input logic [31:0] data, output logic [31:0] rdata);
      logic [IdWidth-1:0] acc_id;
      logic               is_cmd;
      int                 lat;
      acc_id = IdWidth'(take_bits(IdWidth));
      is_cmd = !is_read && (off <= 6'd3);  // Enable, flush, L1 flush, selective flush
      if (!is_read) clear_counts();
      while (!gnt || r_valid) @(negedge clk_i);  // Previous response must be over
      req   = 1'b1;
      wen   = is_read;
      addr  = {24'h0, off, 2'b00};
      wdata = data;
      id    = acc_id;
      @(negedge clk_i);
      req = 1'b0;
      lat = 1;
      while (!r_valid) begin
         if (gnt) note_error("gnt_o high while a command is in flight");
         @(negedge clk_i);
         lat++;
      end
      if (is_cmd && lat < 2) note_error($sformatf("command answered after %0d cycle", lat));
      if (!is_cmd && lat != 1) note_error($sformatf("access answered after %0d cycles", lat));
      if (r_id !== acc_id) note_error($sformatf("r_id_o %0h, expected %0h", r_id, acc_id));
      if (r_opc !== 1'b0) note_error($sformatf("r_opc_o %b, expected 0", r_opc));
      rdata = r_rdata;
   endtask

   task automatic bus_write(input logic [5:0] off, input logic [31:0] data);
      logic [31:0] rdata;
      bus_access(1'b0, off, data, rdata);
      if (rdata !== 32'h0) note_error($sformatf("write to %0d answered %h", off, rdata));
   endtask

   task automatic bus_read(input logic [5:0] off, input logic [31:0] exp);
      logic [31:0] rdata;
      bus_access(1'b1, off, 32'h0, rdata);
      if (rdata !== exp) note_error($sformatf("read %0d gave %h, expected %h", off, rdata, exp));
   endtask

   task automatic report_test(input string name, input int start);
      $display("test %s %s", name, (errors == start) ? "ok" : "failed");
   endtask

   task automatic test_reset();
      int start;
      start = errors;
      if (l1_bypass_req !== '1 || l2_disable_req !== '1) note_error("caches not off after reset");
      if (l2_enable_req !== '0 || l1_flush_req !== '0 || l2_flush_req !== '0 ||
          l1_sel_req !== '0 || l2_sel_req !== '0) note_error("request high after reset");
      bus_read(6'd0, 32'h0);
      bus_read(6'd1, 32'h0);
      bus_read(6'd3, 32'h0);
      bus_read(6'd7, 32'h0);
      bus_read(6'd5, 32'hDEAD_CA5E);
      report_test("reset", start);
   endtask

   task automatic test_enable();
      int start;
      start = errors;
      bus_write(6'd0, 32'h1);
      if (l1_bypass_req !== '0 || l2_enable_req !== '1) note_error("caches not enabled");
      if (ack_vec[0] !== {{NbBanks{1'b1}}, {NbCores{1'b0}}}) note_error("answer before acks");
      bus_read(6'd0, (32'h1 << NU) - 1);
      bus_write(6'd0, 32'h0);
      if (l1_bypass_req !== '1 || l2_disable_req !== '1) note_error("caches not disabled");
      if (ack_vec[0][NbCores-1:0] !== '1 || ack_vec[1][NU-1:NbCores] !== '1)
         note_error("disable answered before acks");
      bus_read(6'd0, 32'h0);
      report_test("enable", start);
   endtask

   task automatic test_flush();
      int start;
      start = errors;
      bus_write(6'd1, 32'h1);
      check_counts(2, 1, 1);
      bus_read(6'd1, 32'h0);
      bus_write(6'd2, 32'h1);
      check_counts(2, 1, 0);  // Banks stay out of an L1 flush
      bus_read(6'd1, 32'h0);
      report_test("flush", start);
   endtask

   task automatic test_sel_flush();
      int          start;
      logic [31:0] sel_addr;
      start    = errors;
      sel_addr = take_bits(32);
      bus_write(6'd3, sel_addr);
      if (l1_sel_addr !== sel_addr || l2_sel_addr !== sel_addr) note_error("flush address");
      check_counts(3, 1, 1);
      bus_read(6'd3, sel_addr);
      report_test("sel_flush", start);
   endtask

   task automatic test_prefetch();
      int          start;
      logic [31:0] value;
      start = errors;
      value = take_bits(32);
      bus_write(6'd7, value);
      if (prefetch !== value[NbCores-1:0]) note_error("prefetch_enable_o mismatch");
      bus_read(6'd7, value & ((32'h1 << NbCores) - 1));
      report_test("prefetch", start);
   endtask

   initial begin
      repeat (NumTests * 400) @(posedge clk_i);
      $display("Timeout: run not done after %0d cycles", NumTests * 400);
      $display("*** TEST FAILED ***");
      $finish;
   end

   initial begin
      rst_ni  = 1'b0;
      req     = 1'b0;
      addr    = '0;
      wen     = 1'b0;
      wdata   = '0;
      id      = '0;
      ack_vec = {{NU{1'b0}}, {NU{1'b0}}, {{NbBanks{1'b1}}, {NbCores{1'b0}}},
                 {{NbBanks{1'b0}}, {NbCores{1'b1}}}};  // Bypass and disable acked
      tgt     = ack_vec;
      repeat (3) @(posedge clk_i);
      @(negedge clk_i);
      rst_ni = 1'b1;
      test_reset();
      test_enable();
      test_flush();
      test_sel_flush();
      test_prefetch();
      errors += uut.i_fsm.i_props.fail_cnt;
      $display("tests: %0d  errors: %0d", NumTests, errors);
      if (errors == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire
